//--- Makefile
TOP = tb_simd

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	verilator --binary --timing --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | awk '{ print } /^ALL CHECKS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- all.f
+incdir+.
simd_isa_pkg.sv
simd_data_pkg.sv
simd_op_if.sv
simd_operand.sv
simd_reg_file.sv
simd_lane.sv
simd_writeback.sv
simd_core_top.sv
tb_simd.sv

//--- simd_core_top.sv
// operand and execute slice; the host supplies instructions and warp ids, with no fetch or hazard check
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_core_top (
	input  logic                                     i_clk,
	input  logic                                     i_rst,
	// instruction input
	input  logic                                     i_inst_rdy,
	output logic                                     o_inst_ack,
	input  logic [`SIMD_INST_BW-1:0]                 i_inst,
	input  simd_data_pkg::wid_t                      i_wid,
	input  logic [$bits(simd_data_pkg::reg_idx_t):0] i_reg_per_warp,
	// constant table load
	input  logic                                     i_lut_we,
	input  logic [$clog2(`SIMD_CONST_LUT)-1:0]       i_lut_addr,
	input  simd_data_pkg::lane_data_t                i_lut_data,
	// result output
	output logic                                     o_res_rdy,
	input  logic                                     i_res_ack,
	output simd_data_pkg::wid_t                      o_res_wid,
	output simd_data_pkg::reg_addr_t                 o_res_dst,
	output simd_data_pkg::row_t                      o_res_data
);
	import simd_data_pkg::*;

	// register file wiring
	logic      reg_re;
	reg_addr_t reg_raddr;
	row_t      reg_row;
	logic      reg_we;
	reg_addr_t reg_waddr;
	row_t      reg_wdata;

	// operand stage to lanes and writeback
	simd_op_if u_op ();

	// ==================================================
	// operand stage and register file
	// ==================================================
	simd_operand u_operand (
		.i_clk, .i_rst,
		.i_inst_rdy, .o_inst_ack, .i_inst, .i_wid, .i_reg_per_warp,
		.i_lut_we, .i_lut_addr, .i_lut_data,
		.o_reg_re    (reg_re),
		.o_reg_raddr (reg_raddr),
		.op          (u_op.src)
	);

	simd_reg_file u_reg_file (
		.i_clk,
		.i_re    (reg_re),
		.i_raddr (reg_raddr),
		.o_rdata (reg_row),
		.i_we    (reg_we),
		.i_waddr (reg_waddr),
		.i_wdata (reg_wdata)
	);

	// ==================================================
	// lanes and writeback
	// ==================================================
	// each lane owns one word of the row
	for (genvar gi = 0; gi < `SIMD_VDIM; gi++) begin : g_lane
		simd_lane #(.LANE(gi)) u_lane (
			.i_clk, .i_rst,
			.op         (u_op.lane),
			.i_reg_data (reg_row[gi]),
			.o_result   (o_res_data[gi])
		);
	end

	simd_writeback u_writeback (
		.i_clk, .i_rst,
		.op        (u_op.drain),
		.i_row     (o_res_data),
		.o_res_rdy, .i_res_ack, .o_res_wid, .o_res_dst,
		.o_we      (reg_we),
		.o_waddr   (reg_waddr),
		.o_wdata   (reg_wdata)
	);

endmodule

//--- simd_data_pkg.sv
// datapath types, sized from the shared defines so the two must be compiled with the same header
`include "simd_defines.svh"

package simd_data_pkg;

	// ==================================================
	// words and rows
	// ==================================================
	// one lane word
	typedef logic [`SIMD_DATA_BW-1:0] lane_data_t;
	// one word per lane, index is the lane number
	typedef lane_data_t [`SIMD_VDIM-1:0] row_t;

	// ==================================================
	// addressing
	// ==================================================
	// absolute row address in the register file
	typedef logic [$clog2(`SIMD_REG_WORDS)-1:0] reg_addr_t;
	// warp id
	typedef logic [$clog2(`SIMD_MAX_WARP)-1:0] wid_t;
	// register index inside one warp, as coded in the isa
	typedef logic [2:0] reg_idx_t;

endpackage

//--- simd_defines.svh
// simd slice sizes, which must stay consistent with the 2-bit lut and 3-bit register isa fields
`ifndef SIMD_DEFINES_SVH
`define SIMD_DEFINES_SVH

// ==================================================
// datapath shape
// ==================================================
// lanes per warp row
`define SIMD_VDIM 4
// bits per lane word
`define SIMD_DATA_BW 16

// ==================================================
// storage and instruction sizes
// ==================================================
// warps sharing the register file
`define SIMD_MAX_WARP 4
// total register rows, split evenly between warps
`define SIMD_REG_WORDS 32
// constant lookup table depth, indexed by 2 source bits
`define SIMD_CONST_LUT 4
// opcode 3 + shamt 4 + to_reg 1 + dst 3 + two 5-bit sources
`define SIMD_INST_BW 21

`endif

//--- simd_isa_pkg.sv
// instruction set types only; the field layout is fixed at 21 bits and source a is the shifted one
package simd_isa_pkg;

	// alu operations, mul keeps the low half
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_AND = 3'd3,
		OP_OR  = 3'd4,
		OP_XOR = 3'd5,
		OP_SHL = 3'd6,
		OP_SHR = 3'd7
	} opcode_e;

	// what a lane selects for one operand
	// lut entries are folded into SRC_CONST during decode
	typedef enum logic [1:0] {
		SRC_CONST = 2'd0,
		SRC_LANE  = 2'd1,
		SRC_REG   = 2'd2
	} src_kind_e;

	// raw instruction word, msb first
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] shamt;
		logic       to_reg;
		logic [2:0] dst;
		logic [4:0] src_a;
		logic [4:0] src_b;
	} inst_t;

	// one source after decode
	typedef struct packed {
		src_kind_e  kind;
		// constant comes from the table, not the field itself
		logic       is_lut;
		// immediate, lut index or register index
		logic [3:0] field;
	} src_dec_t;

	// 0xxxx imm, 100xx lane, 101xx lut, 11xxx register
	function automatic src_dec_t decode_src(input logic [4:0] src);
		src_dec_t d;
		d.field = src[3:0];
		d.is_lut = 1'b0;
		casez (src)
			5'b0????: d.kind = SRC_CONST;
			5'b100??: d.kind = SRC_LANE;
			5'b101??: begin
				d.kind = SRC_CONST;
				d.is_lut = 1'b1;
			end
			default: d.kind = SRC_REG;
		endcase
		return d;
	endfunction

endpackage

//--- simd_lane.sv
// one lane of the row; the shifts use source a only and fill with zeros
`timescale 1ns/1ps

module simd_lane #(
	parameter int LANE = 0
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	simd_op_if.lane                   op,
	input  simd_data_pkg::lane_data_t i_reg_data,
	output simd_data_pkg::lane_data_t o_result
);
	import simd_isa_pkg::*;
	import simd_data_pkg::*;

	lane_data_t a;
	lane_data_t b;
	lane_data_t alu;

	// operand mux
	function automatic lane_data_t pick_src(
		input src_kind_e  kind,
		input lane_data_t cst,
		input lane_data_t reg_data
	);
		case (kind)
			SRC_CONST: return cst;
			SRC_LANE:  return lane_data_t'(LANE);
			SRC_REG:   return reg_data;
			default:   return '0;
		endcase
	endfunction

	assign a = pick_src(op.kind_a, op.const_a, i_reg_data);
	assign b = pick_src(op.kind_b, op.const_b, i_reg_data);

	// alu, all results wrap at the lane width
	always_comb begin
		case (op.opcode)
			OP_ADD:  alu = a + b;
			OP_SUB:  alu = a - b;
			// low half of the product
			OP_MUL:  alu = a * b;
			OP_AND:  alu = a & b;
			OP_OR:   alu = a | b;
			OP_XOR:  alu = a ^ b;
			OP_SHL:  alu = a << op.shamt;
			OP_SHR:  alu = a >> op.shamt;
			default: alu = '0;
		endcase
	end

	// result register, loads on an op transfer
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_result <= '0;
		end else if (op.rdy && op.ack) begin
			o_result <= alu;
		end
	end

endmodule

//--- simd_op_if.sv
// decoded op bundle with rdy/ack, transfer happens on an edge where rdy and ack are both high
`timescale 1ns/1ps

interface simd_op_if;
	import simd_isa_pkg::*;
	import simd_data_pkg::*;

	// handshake
	logic       rdy;
	logic       ack;

	// operation, shamt only used by the shifts
	opcode_e    opcode;
	logic [3:0] shamt;

	// operand selects
	src_kind_e  kind_a;
	src_kind_e  kind_b;
	// constants, zero unless the kind is SRC_CONST
	lane_data_t const_a;
	lane_data_t const_b;

	// writeback info carried along with the op
	logic       to_reg;
	reg_addr_t  waddr;
	wid_t       wid;

	// operand stage side
	modport src (
		output rdy, opcode, shamt, kind_a, kind_b, const_a, const_b, to_reg, waddr, wid,
		input  ack
	);

	// lanes watch the handshake, they never drive it
	modport lane (
		input rdy, ack, opcode, shamt, kind_a, kind_b, const_a, const_b
	);

	// writeback owns ack for the whole lane stage
	modport drain (
		input  rdy, to_reg, waddr, wid,
		output ack
	);

endinterface

//--- simd_operand.sv
// operand stage; no hazard check, so one warp's instructions must be at least four transfers apart
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_operand (
	input  logic                                     i_clk,
	input  logic                                     i_rst,
	input  logic                                     i_inst_rdy,
	output logic                                     o_inst_ack,
	input  logic [`SIMD_INST_BW-1:0]                 i_inst,
	input  simd_data_pkg::wid_t                      i_wid,
	input  logic [$bits(simd_data_pkg::reg_idx_t):0] i_reg_per_warp,
	input  logic                                     i_lut_we,
	input  logic [$clog2(`SIMD_CONST_LUT)-1:0]       i_lut_addr,
	input  simd_data_pkg::lane_data_t                i_lut_data,
	output logic                                     o_reg_re,
	output simd_data_pkg::reg_addr_t                 o_reg_raddr,
	simd_op_if.src                                   op
);
	import simd_isa_pkg::*;
	import simd_data_pkg::*;

	inst_t      inst;
	src_dec_t   dec_a;
	src_dec_t   dec_b;
	lane_data_t const_lut [`SIMD_CONST_LUT];
	lane_data_t const_a_w;
	lane_data_t const_b_w;
	reg_idx_t   reg_field;
	reg_addr_t  warp_base;
	logic       inst_xfer;
	logic       op_xfer;

	// ==================================================
	// handshake
	// ==================================================
	assign op_xfer = op.rdy & op.ack;
	// free when empty or when the held op leaves this edge
	assign o_inst_ack = !op.rdy || op_xfer;
	assign inst_xfer = i_inst_rdy & o_inst_ack;

	// ==================================================
	// decode
	// ==================================================
	assign inst = inst_t'(i_inst);
	assign dec_a = decode_src(inst.src_a);
	assign dec_b = decode_src(inst.src_b);
	// row 0 of this warp
	assign warp_base = reg_addr_t'(i_wid) * reg_addr_t'(i_reg_per_warp);

	always_comb begin
		// direct imm is zero extended, lut entry taken as is
		const_a_w = '0;
		const_b_w = '0;
		if (dec_a.kind == SRC_CONST) begin
			const_a_w = dec_a.is_lut ? const_lut[dec_a.field[1:0]] : lane_data_t'(dec_a.field);
		end
		if (dec_b.kind == SRC_CONST) begin
			const_b_w = dec_b.is_lut ? const_lut[dec_b.field[1:0]] : lane_data_t'(dec_b.field);
		end
	end

	// single read port, so two register sources share one ORed index
	always_comb begin
		reg_field = '0;
		if (dec_a.kind == SRC_REG) begin
			reg_field = reg_field | dec_a.field[2:0];
		end
		if (dec_b.kind == SRC_REG) begin
			reg_field = reg_field | dec_b.field[2:0];
		end
	end

	// read lands together with op.rdy
	assign o_reg_re = inst_xfer && (dec_a.kind == SRC_REG || dec_b.kind == SRC_REG);
	assign o_reg_raddr = warp_base + reg_addr_t'(reg_field);

	// ==================================================
	// state
	// ==================================================
	// constant table, loaded by the host
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < `SIMD_CONST_LUT; i++) begin
				const_lut[i] <= '0;
			end
		end else if (i_lut_we) begin
			const_lut[i_lut_addr] <= i_lut_data;
		end
	end

	// op stage occupancy
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			op.rdy <= 1'b0;
		end else if (inst_xfer) begin
			op.rdy <= 1'b1;
		end else if (op_xfer) begin
			op.rdy <= 1'b0;
		end
	end

	// decoded fields, held while stalled
	always_ff @(posedge i_clk) begin
		if (inst_xfer) begin
			op.opcode  <= inst.opcode;
			op.shamt   <= inst.shamt;
			op.kind_a  <= dec_a.kind;
			op.kind_b  <= dec_b.kind;
			op.const_a <= const_a_w;
			op.const_b <= const_b_w;
			op.to_reg  <= inst.to_reg;
			op.wid     <= i_wid;
			op.waddr   <= warp_base + reg_addr_t'(inst.dst);
		end
	end

endmodule

//--- simd_reg_file.sv
// one read and one write port, read is synchronous and returns the word being written this edge
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_reg_file (
	input  logic                     i_clk,
	// read port
	input  logic                     i_re,
	input  simd_data_pkg::reg_addr_t i_raddr,
	output simd_data_pkg::row_t      o_rdata,
	// write port
	input  logic                     i_we,
	input  simd_data_pkg::reg_addr_t i_waddr,
	input  simd_data_pkg::row_t      i_wdata
);
	import simd_data_pkg::*;

	// one full lane row per word
	row_t mem [`SIMD_REG_WORDS];

	// write port
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// read port
	// output only moves on a read, so a stalled op keeps its row
	always_ff @(posedge i_clk) begin
		if (i_re) begin
			if (i_we && i_waddr == i_raddr) begin
				// write-first bypass
				o_rdata <= i_wdata;
			end else begin
				o_rdata <= mem[i_raddr];
			end
		end
	end

endmodule

//--- simd_stim.txt
# L lut_addr lut_data
# I wid inst exp_wid exp_dst lane0 lane1 lane2 lane3 (all hex)
I 0 0000A3 0 00 0008 0008 0008 0008
I 1 040065 1 08 FFFE FFFE FFFE FFFE
I 2 0801ED 2 10 00C3 00C3 00C3 00C3
I 3 0C018A 3 18 0008 0008 0008 0008
I 0 100183 0 00 000F 000F 000F 000F
I 1 14018A 1 08 0006 0006 0006 0006
I 2 1B0120 2 10 9000 9000 9000 9000
I 3 1C41C7 3 18 0007 0007 0007 0007
I 0 000204 0 00 0004 0005 0006 0007
I 1 080210 1 08 0000 0001 0004 0009
I 2 190200 2 10 0000 0010 0020 0030
I 3 040150 3 18 000A 0009 0008 0007
L 0 1234
L 1 FF00
L 2 00FF
L 3 8001
I 0 000295 0 00 1134 1134 1134 1134
I 1 1402D7 1 08 80FE 80FE 80FE 80FE
I 2 1FC2E0 2 10 0001 0001 0001 0001
I 3 080290 3 18 0000 1234 2468 369C
I 0 002614 0 01 1234 1235 1236 1237
I 1 082607 1 09 0000 0007 000E 0015
I 2 1026B0 2 11 FF00 FF01 FF02 FF03
I 3 0025E0 3 19 000F 000F 000F 000F
I 0 000321 0 00 1235 1236 1237 1238
I 1 000339 1 08 0000 000E 001C 002A
I 2 140330 2 10 FF00 FF00 FF00 FF00
I 3 1A0320 3 18 0F00 0F00 0F00 0F00

//--- simd_writeback.sv
// lane stage control; a result waits for i_res_ack and writes its row back only if to_reg is set
`timescale 1ns/1ps

module simd_writeback (
	input  logic                     i_clk,
	input  logic                     i_rst,
	simd_op_if.drain                 op,
	input  simd_data_pkg::row_t      i_row,
	// result handshake
	output logic                     o_res_rdy,
	input  logic                     i_res_ack,
	output simd_data_pkg::wid_t      o_res_wid,
	output simd_data_pkg::reg_addr_t o_res_dst,
	// register file write port
	output logic                     o_we,
	output simd_data_pkg::reg_addr_t o_waddr,
	output simd_data_pkg::row_t      o_wdata
);
	import simd_data_pkg::*;

	logic      full;
	logic      to_reg_q;
	wid_t      wid_q;
	reg_addr_t waddr_q;
	logic      op_xfer;
	logic      res_xfer;

	// ==================================================
	// handshakes
	// ==================================================
	assign res_xfer = full & i_res_ack;
	// take a new op when empty or when the current result leaves
	assign op.ack = !full || res_xfer;
	assign op_xfer = op.rdy & op.ack;

	// lane stage occupancy
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full <= 1'b0;
		end else if (op_xfer) begin
			full <= 1'b1;
		end else if (res_xfer) begin
			full <= 1'b0;
		end
	end

	// side info that travels beside the lane results
	always_ff @(posedge i_clk) begin
		if (op_xfer) begin
			to_reg_q <= op.to_reg;
			wid_q    <= op.wid;
			waddr_q  <= op.waddr;
		end
	end

	// ==================================================
	// outputs
	// ==================================================
	assign o_res_rdy = full;
	assign o_res_wid = wid_q;
	assign o_res_dst = waddr_q;

	// write back on the same edge the result is taken
	assign o_we    = res_xfer & to_reg_q;
	assign o_waddr = waddr_q;
	assign o_wdata = i_row;

endmodule

//--- tb_simd.sv
// self-checking bench for simd_core_top; needs simd_stim.txt in the run directory, 8 regs per warp
`timescale 1ns/1ps
`include "simd_defines.svh"

module tb_simd;
	import simd_data_pkg::*;

	logic                            i_clk;
	logic                            i_rst;
	logic                            i_inst_rdy;
	logic                            o_inst_ack;
	logic [`SIMD_INST_BW-1:0]        i_inst;
	wid_t                            i_wid;
	logic [$bits(reg_idx_t):0]       i_reg_per_warp;
	logic                            i_lut_we;
	logic [$clog2(`SIMD_CONST_LUT)-1:0] i_lut_addr;
	lane_data_t                      i_lut_data;
	logic                            o_res_rdy;
	logic                            i_res_ack;
	wid_t                            o_res_wid;
	reg_addr_t                       o_res_dst;
	row_t                            o_res_data;

	// expected results, in transfer order
	int        exp_idx_q[$];
	wid_t      exp_wid_q[$];
	reg_addr_t exp_dst_q[$];
	row_t      exp_row_q[$];

	int          value_errors = 0;
	int          other_errors = 0;
	int          results_seen = 0;
	int          fd;
	bit          drive_done = 1'b0;
	bit          abort = 1'b0;
	logic [15:0] lfsr = 16'd6316;

	simd_core_top i_dut (.*);

	// 10 ns clock
	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// ==================================================
	// random bits
	// ==================================================
	// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic random_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic check_row(input string name, input row_t expected, input row_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t expected,
			input reg_addr_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	// one cycle table write, entered and left 1 ns after an edge
	task automatic write_lut(input logic [31:0] addr, input logic [31:0] data);
		i_lut_we   = 1'b1;
		i_lut_addr = addr[$clog2(`SIMD_CONST_LUT)-1:0];
		i_lut_data = data[15:0];
		@(posedge i_clk);
		#1;
		i_lut_we = 1'b0;
	endtask

	task automatic send_inst(input int idx, input logic [31:0] wid, input logic [31:0] inst,
			input logic [31:0] ewid, input logic [31:0] edst, input row_t erow);
		int unsigned gap;
		int          cycles;
		bit          taken;
		cycles = 0;
		taken  = 1'b0;
		// random idle gap before rdy goes up
		random_bits(2, gap);
		repeat (gap) begin
			@(posedge i_clk);
			#1;
		end
		i_inst_rdy = 1'b1;
		i_inst     = inst[`SIMD_INST_BW-1:0];
		i_wid      = wid[1:0];
		// ack seen at the falling edge means the transfer lands on the next rise
		while (!taken && cycles < 200) begin
			@(negedge i_clk);
			if (o_inst_ack) begin
				taken = 1'b1;
			end else begin
				cycles++;
			end
		end
		if (taken) begin
			exp_idx_q.push_back(idx);
			exp_wid_q.push_back(ewid[1:0]);
			exp_dst_q.push_back(edst[4:0]);
			exp_row_q.push_back(erow);
			@(posedge i_clk);
			#1;
		end else begin
			$display("timeout: instruction %0d was not accepted within 200 cycles", idx);
			other_errors++;
			abort = 1'b1;
		end
		i_inst_rdy = 1'b0;
	endtask

	// walks the stim file line by line
	task automatic run_driver();
		string       line;
		int          idx;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] w;
		logic [31:0] inst;
		logic [31:0] ew;
		logic [31:0] ed;
		logic [31:0] l0;
		logic [31:0] l1;
		logic [31:0] l2;
		logic [31:0] l3;
		row_t        erow;
		idx = 0;
		while (!$feof(fd) && !abort) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "L %h %h", a, d) == 2) begin
					write_lut(a, d);
				end else if ($sscanf(line, "I %h %h %h %h %h %h %h %h",
						w, inst, ew, ed, l0, l1, l2, l3) == 8) begin
					erow[0] = l0[15:0];
					erow[1] = l1[15:0];
					erow[2] = l2[15:0];
					erow[3] = l3[15:0];
					send_inst(idx, w, inst, ew, ed, erow);
					idx++;
				end else begin
					$display("stim file line not understood: %s", line);
					other_errors++;
				end
			end
		end
		drive_done = 1'b1;
	endtask

	// ==================================================
	// result side
	// ==================================================
	// random ack stalls, compares each row as it is taken
	task automatic collect_results();
		int unsigned v;
		int          idle;
		int          idx;
		idle = 0;
		while (!(drive_done && exp_row_q.size() == 0) && !abort) begin
			random_bits(2, v);
			i_res_ack = (v != 0);
			@(negedge i_clk);
			if (o_res_rdy && i_res_ack) begin
				idle = 0;
				if (exp_row_q.size() == 0) begin
					$display("result row appeared with no instruction outstanding");
					other_errors++;
				end else begin
					idx = exp_idx_q.pop_front();
					check_addr($sformatf("inst %0d wid", idx),
						reg_addr_t'(exp_wid_q.pop_front()), reg_addr_t'(o_res_wid));
					check_addr($sformatf("inst %0d dst", idx), exp_dst_q.pop_front(), o_res_dst);
					check_row($sformatf("inst %0d row", idx), exp_row_q.pop_front(), o_res_data);
					results_seen++;
				end
			end else if (exp_row_q.size() != 0) begin
				idle++;
				if (idle >= 200) begin
					$display("timeout: no result row within 200 cycles");
					other_errors++;
					abort = 1'b1;
				end
			end
			@(posedge i_clk);
			#1;
		end
		i_res_ack = 1'b1;
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		i_rst          = 1'b1;
		i_inst_rdy     = 1'b0;
		i_inst         = '0;
		i_wid          = '0;
		i_reg_per_warp = 4'd8;
		i_lut_we       = 1'b0;
		i_lut_addr     = '0;
		i_lut_data     = '0;
		i_res_ack      = 1'b0;
		repeat (4) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		fd = $fopen("simd_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open simd_stim.txt for reading");
			other_errors++;
		end else begin
			fork
				run_driver();
				collect_results();
			join
			$fclose(fd);
		end
		$display("value errors %0d, other errors %0d, results checked %0d",
			value_errors, other_errors, results_seen);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
